// File: project.f
source/bscan_pkg.sv
source/bscan_instr_decode.sv
source/bscan_mode_ctrl.sv
source/bscan_actest_gen.sv
source/bscan_dr_tdo.sv
source/bscan_top.sv
verif/bscan_props.sv
verif/tb_bscan.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the boundary-scan testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f project.f --top-module tb_bscan -Mdir obj_dir
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

./obj_dir/Vtb_bscan +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "Simulation finished: PASS" "$LOG"; then
   exit 0
fi
echo "pass message not found in $LOG"
exit 1

// File: source/bscan_actest_gen.sv
// AC test waveform generation
// Toggle divider, 1149.6 AC signal, d6select and test receiver init

`timescale 1ns/1ps

module bscan_actest_gen
(
   input  logic                           ftap_tck,
   input  logic                           powergood_rst_trst_b,
   // Decoded instruction flags
   input  logic [bscan_pkg::NUM_INST-1:0] i_inst,
   input  logic [bscan_pkg::NUM_INST-1:0] i_early,
   // TAP FSM state strobes
   input  logic                           i_tlrs,
   input  logic                           i_rti,
   input  logic                           i_e1dr,
   input  logic                           i_e2dr,
   input  logic                           i_capture_dr,
   // Test waveforms
   output logic                           o_extogsig_b,
   output logic                           o_d6actestsig_b,
   output logic                           o_d6select,
   output logic                           o_d6init
);

   import bscan_pkg::*;

   logic by_two;
   logic ac_sig;
   // Rising-edge copy of PULSE or TRAIN, steers the AC output mux
   logic d6_mxsel;
   logic pt_early_dly;
   logic cap_extest_dly;
   logic pulse_or_train;
   logic pt_early;

   assign pulse_or_train = i_inst[IDX_PULSE] | i_inst[IDX_TRAIN];
   assign pt_early       = i_early[IDX_PULSE] | i_early[IDX_TRAIN];

   // *************************************************************************
   // Falling-edge flops
   // *************************************************************************
   always_ff @(negedge ftap_tck or negedge powergood_rst_trst_b)
   begin
      if (!powergood_rst_trst_b)
      begin
         by_two         <= 1'b0;
         ac_sig         <= 1'b0;
         pt_early_dly   <= 1'b0;
         cap_extest_dly <= 1'b0;
      end
      else if (i_tlrs)
      begin
         by_two         <= 1'b0;
         ac_sig         <= 1'b0;
         pt_early_dly   <= 1'b0;
         cap_extest_dly <= 1'b0;
      end
      else
      begin
         // Divide by two in run-test/idle under EXTEST_TOGGLE
         by_two         <= ~by_two & i_inst[IDX_TOGGLE] & i_rti;
         // TRAIN toggles every edge, PULSE parks high in RTI
         ac_sig         <= ~(ac_sig & i_inst[IDX_TRAIN]) & i_rti;
         pt_early_dly   <= pt_early;
         cap_extest_dly <= i_capture_dr & i_inst[IDX_EXTEST];
      end
   end

   // Selects the 1149.6 waveform one rising edge after PULSE or TRAIN
   always_ff @(posedge ftap_tck or negedge powergood_rst_trst_b)
   begin
      if (!powergood_rst_trst_b)
         d6_mxsel <= 1'b0;
      else if (i_tlrs)
         d6_mxsel <= 1'b0;
      else
         d6_mxsel <= pulse_or_train;
   end

   // *************************************************************************
   // Outputs
   // *************************************************************************
   // Active-low waveforms idle high
   assign o_extogsig_b    = ~by_two;
   assign o_d6actestsig_b = d6_mxsel ? ~ac_sig : o_extogsig_b;
   assign o_d6select      = pulse_or_train & pt_early_dly;

   // Receiver init in Exit1/Exit2-DR for AC tests
   // plain EXTEST uses capture-DR seen on the next falling edge
   assign o_d6init = pulse_or_train    ? (i_e1dr | i_e2dr) :
                     i_inst[IDX_EXTEST] ? cap_extest_dly    : 1'b0;

endmodule

// File: source/bscan_dr_tdo.sv
// Boundary register DR strobes and final TDO selection
// Gated capture/shift/update, falling-edge update copy, TDO retiming

`timescale 1ns/1ps

module bscan_dr_tdo
(
   input  logic                           ftap_tck,
   input  logic                           powergood_rst_trst_b,
   input  logic [bscan_pkg::NUM_INST-1:0] i_inst,
   // TAP FSM strobes
   input  logic                           i_tlrs,
   input  logic                           i_capture_dr,
   input  logic                           i_shift_dr,
   input  logic                           i_update_dr,
   input  logic                           i_shift_ir_neg,
   // Serial data
   input  logic                           i_bscan_tdo,
   input  logic                           i_pre_tdo,
   // Boundary register strobes
   output logic                           o_capturedr,
   output logic                           o_shiftdr,
   output logic                           o_updatedr,
   output logic                           o_updatedr_clk,
   output logic                           o_tdo
);

   import bscan_pkg::*;

   logic shift_en;
   logic chain_sel;
   logic tdo_q;

   // *************************************************************************
   // Gated DR strobes
   // *************************************************************************
   assign shift_en    = |(i_inst & MASK_SHIFT);
   assign o_capturedr = i_capture_dr & shift_en;
   assign o_shiftdr   = i_shift_dr & shift_en;
   assign o_updatedr  = i_update_dr & shift_en;

   // Update copy for cells that latch on the falling edge
   always_ff @(negedge ftap_tck or negedge powergood_rst_trst_b)
   begin
      if (!powergood_rst_trst_b)
         o_updatedr_clk <= 1'b0;
      else
         o_updatedr_clk <= o_updatedr;
   end

   // *************************************************************************
   // TDO retiming
   // *************************************************************************
   // Chain output moves to the falling edge as 1149.1 requires
   // Cleared in capture so stale chain data never reaches TDO
   always_ff @(negedge ftap_tck or negedge powergood_rst_trst_b)
   begin
      if (!powergood_rst_trst_b)
         tdo_q <= 1'b0;
      else if (i_tlrs || i_capture_dr)
         tdo_q <= 1'b0;
      else if (i_shift_dr)
         tdo_q <= i_bscan_tdo;
   end

   // IR shifting always takes the rest of the TAP path
   assign chain_sel = |(i_inst & MASK_CHAIN);
   assign o_tdo     = (chain_sel & ~i_shift_ir_neg) ? tdo_q : i_pre_tdo;

endmodule

// File: source/bscan_instr_decode.sv
// Boundary-scan instruction decoder
// Current and early (update-IR) one-hot instruction flags

`timescale 1ns/1ps

module bscan_instr_decode
(
   // Instruction register contents
   input  logic [bscan_pkg::IR_WIDTH-1:0] i_ireg,
   input  logic [bscan_pkg::IR_WIDTH-1:0] i_ir_shift_reg,
   // TAP FSM update-IR state
   input  logic                           i_update_ir,
   // Decoded flags
   output logic [bscan_pkg::NUM_INST-1:0] o_inst,
   output logic [bscan_pkg::NUM_INST-1:0] o_early
);

   import bscan_pkg::*;

   // *************************************************************************
   // Opcode table lookup
   // *************************************************************************
   // Unknown opcodes decode to all zeros
   function automatic logic [NUM_INST-1:0] decode_word(input logic [IR_WIDTH-1:0] word);
      logic [NUM_INST-1:0] hit;
      hit             = '0;
      hit[IDX_SAMPRE] = (word == CODE_SAMPLE_PRELOAD);
      hit[IDX_CLAMP]  = (word == CODE_CLAMP);
      hit[IDX_HIGHZ]  = (word == CODE_HIGHZ);
      hit[IDX_EXTEST] = (word == CODE_EXTEST);
      hit[IDX_TOGGLE] = (word == CODE_EXTEST_TOGGLE);
      hit[IDX_PULSE]  = (word == CODE_EXTEST_PULSE);
      hit[IDX_TRAIN]  = (word == CODE_EXTEST_TRAIN);
      return hit;
   endfunction

   // Opcode waiting in the shift stage of the IR
   logic [NUM_INST-1:0] shift_hit;
   // Shift-stage opcode qualified by update-IR
   logic [NUM_INST-1:0] upd_hit;

   // *************************************************************************
   // Current instruction
   // *************************************************************************
   assign o_inst = decode_word(i_ireg);

   // *************************************************************************
   // Early instruction
   // *************************************************************************
   // During update-IR the new opcode is still in the shift stage
   // Flag it one state ahead so the falling-edge deglitch flops are primed
   assign shift_hit = decode_word(i_ir_shift_reg);
   assign upd_hit   = shift_hit & {NUM_INST{i_update_ir}};

   // Early flag covers both the running and the incoming instruction
   assign o_early = o_inst | upd_hit;

endmodule

// File: source/bscan_mode_ctrl.sv
// Boundary register control levels
// Chain enable, mode, high-Z and toggle enable with falling-edge deglitch

`timescale 1ns/1ps

module bscan_mode_ctrl
(
   input  logic                           ftap_tck,
   input  logic                           powergood_rst_trst_b,
   // Decoded instruction flags
   input  logic [bscan_pkg::NUM_INST-1:0] i_inst,
   input  logic [bscan_pkg::NUM_INST-1:0] i_early,
   // Boundary register controls
   output logic                           o_chainen,
   output logic                           o_mode,
   output logic                           o_highz,
   output logic                           o_extogen
);

   import bscan_pkg::*;

   // Group ORs of the current instruction
   logic chainen_cur;
   logic mode_cur;
   // Group ORs of the early instruction
   logic chainen_early;
   logic mode_early;
   // Early values captured on the falling edge
   logic chainen_early_dly;
   logic mode_early_dly;
   logic highz_early_dly;
   logic extog_early_dly;

   // *************************************************************************
   // Instruction groups
   // *************************************************************************
   assign chainen_cur   = |(i_inst & MASK_CHAIN);
   assign mode_cur      = |(i_inst & MASK_MODE);
   assign chainen_early = |(i_early & MASK_CHAIN);
   assign mode_early    = |(i_early & MASK_MODE);

   // *************************************************************************
   // Falling-edge deglitch flops
   // *************************************************************************
   // Pins change on the falling edge after update-IR as 1149.1 asks
   always_ff @(negedge ftap_tck or negedge powergood_rst_trst_b)
   begin
      if (!powergood_rst_trst_b)
      begin
         chainen_early_dly <= 1'b0;
         mode_early_dly    <= 1'b0;
         highz_early_dly   <= 1'b0;
         extog_early_dly   <= 1'b0;
      end
      else
      begin
         chainen_early_dly <= chainen_early;
         mode_early_dly    <= mode_early;
         highz_early_dly   <= i_early[IDX_HIGHZ];
         extog_early_dly   <= i_early[IDX_TOGGLE];
      end
   end

   // *************************************************************************
   // Output levels
   // *************************************************************************
   // Rise one falling edge after the instruction arrives
   // Drop as soon as the current instruction changes
   assign o_chainen = chainen_cur & chainen_early_dly;
   assign o_mode    = mode_cur & mode_early_dly;
   assign o_highz   = i_inst[IDX_HIGHZ] & highz_early_dly;
   assign o_extogen = i_inst[IDX_TOGGLE] & extog_early_dly;

endmodule

// File: source/bscan_pkg.sv
// Boundary-scan shared constants
// Instruction codes, flag vector indices and instruction group masks

package bscan_pkg;

   // *************************************************************************
   // Instruction register
   // *************************************************************************
   localparam int IR_WIDTH = 8;

   // Opcodes of the supported boundary-scan instructions
   localparam logic [IR_WIDTH-1:0] CODE_SAMPLE_PRELOAD = 8'h01;
   localparam logic [IR_WIDTH-1:0] CODE_CLAMP          = 8'h04;
   localparam logic [IR_WIDTH-1:0] CODE_HIGHZ          = 8'h08;
   localparam logic [IR_WIDTH-1:0] CODE_EXTEST         = 8'h09;
   localparam logic [IR_WIDTH-1:0] CODE_EXTEST_TOGGLE  = 8'h0D;
   localparam logic [IR_WIDTH-1:0] CODE_EXTEST_PULSE   = 8'h0E;
   localparam logic [IR_WIDTH-1:0] CODE_EXTEST_TRAIN   = 8'h0F;

   // *************************************************************************
   // Decoded instruction flag vector
   // *************************************************************************
   localparam int NUM_INST = 7;

   // Bit position of each instruction in the flag vector
   localparam int IDX_SAMPRE = 0;
   localparam int IDX_CLAMP  = 1;
   localparam int IDX_HIGHZ  = 2;
   localparam int IDX_EXTEST = 3;
   localparam int IDX_TOGGLE = 4;
   localparam int IDX_PULSE  = 5;
   localparam int IDX_TRAIN  = 6;

   // Every boundary-scan instruction selects the chain
   localparam logic [NUM_INST-1:0] MASK_CHAIN = {NUM_INST{1'b1}};

   // Instructions where the boundary register drives the pins
   // Sample/preload leaves the pins functional
   localparam logic [NUM_INST-1:0] MASK_MODE =
      MASK_CHAIN & ~(NUM_INST'(1) << IDX_SAMPRE);

   // Instructions that clock data through the boundary register
   // Clamp and high-Z use the bypass path
   localparam logic [NUM_INST-1:0] MASK_SHIFT =
      (NUM_INST'(1) << IDX_SAMPRE) |
      (NUM_INST'(1) << IDX_EXTEST) |
      (NUM_INST'(1) << IDX_TOGGLE) |
      (NUM_INST'(1) << IDX_PULSE)  |
      (NUM_INST'(1) << IDX_TRAIN);

endpackage

// File: source/bscan_top.sv
// Boundary-scan control block top level
// Decoder, control levels, AC waveforms and DR/TDO side

`timescale 1ns/1ps

module bscan_top
(
   // *************************************************************************
   // JTAG clock and reset
   // *************************************************************************
   input  logic                           ftap_tck,
   input  logic                           powergood_rst_trst_b,
   // *************************************************************************
   // TAP FSM and instruction register
   // *************************************************************************
   input  logic [bscan_pkg::IR_WIDTH-1:0] i_ireg,
   input  logic [bscan_pkg::IR_WIDTH-1:0] i_ir_shift_reg,
   input  logic                           i_update_ir,
   input  logic                           i_tlrs,
   input  logic                           i_rti,
   input  logic                           i_e1dr,
   input  logic                           i_e2dr,
   input  logic                           i_capture_dr,
   input  logic                           i_shift_dr,
   input  logic                           i_update_dr,
   input  logic                           i_shift_ir_neg,
   // Serial data from the chain and from the rest of the TAP
   input  logic                           i_bscan_tdo,
   input  logic                           i_pre_tdo,
   // *************************************************************************
   // Boundary register side
   // *************************************************************************
   output logic                           o_bscan_tck,
   output logic                           o_capturedr,
   output logic                           o_shiftdr,
   output logic                           o_updatedr,
   output logic                           o_updatedr_clk,
   output logic                           o_chainen,
   output logic                           o_mode,
   output logic                           o_highz,
   output logic                           o_extogen,
   // AC test signals
   output logic                           o_extogsig_b,
   output logic                           o_d6actestsig_b,
   output logic                           o_d6select,
   output logic                           o_d6init,
   // Final TAP output
   output logic                           o_tdo
);

   import bscan_pkg::*;

   logic [NUM_INST-1:0] inst;
   logic [NUM_INST-1:0] early;

   // Chain runs on the TAP clock itself
   assign o_bscan_tck = ftap_tck;

   bscan_instr_decode u_decode (
      .i_ireg         (i_ireg),
      .i_ir_shift_reg (i_ir_shift_reg),
      .i_update_ir    (i_update_ir),
      .o_inst         (inst),
      .o_early        (early)
   );

   bscan_mode_ctrl u_mode (
      .ftap_tck             (ftap_tck),
      .powergood_rst_trst_b (powergood_rst_trst_b),
      .i_inst               (inst),
      .i_early              (early),
      .o_chainen            (o_chainen),
      .o_mode               (o_mode),
      .o_highz              (o_highz),
      .o_extogen            (o_extogen)
   );

   bscan_actest_gen u_actest (
      .ftap_tck             (ftap_tck),
      .powergood_rst_trst_b (powergood_rst_trst_b),
      .i_inst               (inst),
      .i_early              (early),
      .i_tlrs               (i_tlrs),
      .i_rti                (i_rti),
      .i_e1dr               (i_e1dr),
      .i_e2dr               (i_e2dr),
      .i_capture_dr         (i_capture_dr),
      .o_extogsig_b         (o_extogsig_b),
      .o_d6actestsig_b      (o_d6actestsig_b),
      .o_d6select           (o_d6select),
      .o_d6init             (o_d6init)
   );

   bscan_dr_tdo u_dr_tdo (
      .ftap_tck             (ftap_tck),
      .powergood_rst_trst_b (powergood_rst_trst_b),
      .i_inst               (inst),
      .i_tlrs               (i_tlrs),
      .i_capture_dr         (i_capture_dr),
      .i_shift_dr           (i_shift_dr),
      .i_update_dr          (i_update_dr),
      .i_shift_ir_neg       (i_shift_ir_neg),
      .i_bscan_tdo          (i_bscan_tdo),
      .i_pre_tdo            (i_pre_tdo),
      .o_capturedr          (o_capturedr),
      .o_shiftdr            (o_shiftdr),
      .o_updatedr           (o_updatedr),
      .o_updatedr_clk       (o_updatedr_clk),
      .o_tdo                (o_tdo)
   );

endmodule

// File: verif/bscan_props.sv
// Concurrent checks of the boundary-scan control rules
// Bound into bscan_top, sampled on the TAP clock edges

`timescale 1ns/1ps

module bscan_props
(
   input logic                           ftap_tck,
   input logic                           powergood_rst_trst_b,
   input logic [bscan_pkg::IR_WIDTH-1:0] i_ireg,
   input logic                           i_tlrs,
   input logic                           i_rti,
   input logic                           i_e1dr,
   input logic                           i_e2dr,
   input logic                           i_capture_dr,
   input logic                           i_shift_dr,
   input logic                           i_update_dr,
   input logic                           i_shift_ir_neg,
   input logic                           i_bscan_tdo,
   input logic                           i_pre_tdo,
   input logic                           o_capturedr,
   input logic                           o_shiftdr,
   input logic                           o_updatedr,
   input logic                           o_updatedr_clk,
   input logic                           o_chainen,
   input logic                           o_mode,
   input logic                           o_highz,
   input logic                           o_extogen,
   input logic                           o_extogsig_b,
   input logic                           o_d6actestsig_b,
   input logic                           o_d6select,
   input logic                           o_d6init,
   input logic                           o_tdo
);

   import bscan_pkg::*;

   // Instruction groups straight from the opcode table
   wire is_samp    = (i_ireg == CODE_SAMPLE_PRELOAD);
   wire is_clamp   = (i_ireg == CODE_CLAMP);
   wire is_highz   = (i_ireg == CODE_HIGHZ);
   wire is_extest  = (i_ireg == CODE_EXTEST);
   wire is_toggle  = (i_ireg == CODE_EXTEST_TOGGLE);
   wire is_pulse   = (i_ireg == CODE_EXTEST_PULSE);
   wire is_train   = (i_ireg == CODE_EXTEST_TRAIN);
   wire is_shift   = is_samp | is_extest | is_toggle | is_pulse | is_train;
   wire is_mode    = is_clamp | is_highz | is_extest | is_toggle | is_pulse | is_train;
   wire is_chain   = is_mode | is_samp;
   // TDO taken from the chain flop
   wire tdo_chain  = is_chain & ~i_shift_ir_neg;
   wire tdo_exp    = !tdo_chain ? i_pre_tdo : ((i_capture_dr | i_tlrs) ? 1'b0 : i_bscan_tdo);

   int fail_count = 0;

   function automatic void record_failure(input string what);
      fail_count++;
      $error("rule broken: %s", what);
   endfunction

   // *************************************************************************
   // Boundary register levels and strobes
   // *************************************************************************
   assert property (@(posedge ftap_tck) disable iff (!powergood_rst_trst_b)
      $stable(i_ireg) |-> o_chainen == is_chain && o_mode == is_mode &&
                          o_highz == is_highz && o_extogen == is_toggle)
      else record_failure("control levels do not match the current instruction");
   assert property (@(posedge ftap_tck) disable iff (!powergood_rst_trst_b)
      $stable(i_ireg) && !i_tlrs |-> o_d6select == (is_pulse | is_train))
      else record_failure("d6select does not match PULSE or TRAIN");
   assert property (@(posedge ftap_tck) disable iff (!powergood_rst_trst_b)
      o_capturedr == (i_capture_dr & is_shift) && o_shiftdr == (i_shift_dr & is_shift) &&
      o_updatedr == (i_update_dr & is_shift))
      else record_failure("gated DR strobes are wrong");
   // Falling-edge copy carries the update strobe seen one falling edge earlier
   assert property (@(negedge ftap_tck) disable iff (!powergood_rst_trst_b)
      o_updatedr_clk == $past(o_updatedr))
      else record_failure("updatedr_clk is not the falling-edge copy of updatedr");

   assert property (@(posedge ftap_tck) disable iff (!powergood_rst_trst_b)
      !tdo_chain || i_shift_dr || i_capture_dr || i_tlrs |-> o_tdo == tdo_exp)
      else record_failure("TDO does not follow the chain or pre-TDO rule");
   // Outside capture and shift the chain flop keeps its value
   assert property (@(posedge ftap_tck) disable iff (!powergood_rst_trst_b)
      tdo_chain && $past(tdo_chain) && !i_shift_dr && !i_capture_dr && !i_tlrs |->
      o_tdo == $past(o_tdo))
      else record_failure("TDO flop did not hold outside capture and shift");

   // *************************************************************************
   // Toggle and 1149.6 waveforms
   // *************************************************************************
   assert property (@(posedge ftap_tck) disable iff (!powergood_rst_trst_b)
      is_toggle && i_rti && !i_tlrs |-> o_extogsig_b != $past(o_extogsig_b))
      else record_failure("extogsig_b did not invert under EXTEST_TOGGLE in RTI");
   assert property (@(posedge ftap_tck) disable iff (!powergood_rst_trst_b)
      i_tlrs |-> o_extogsig_b)
      else record_failure("extogsig_b not back at 1 in test-logic-reset");
   // Select flop needs the two previous samples under TRAIN
   assert property (@(posedge ftap_tck) disable iff (!powergood_rst_trst_b)
      is_train && i_rti && !i_tlrs && $past(is_train && !i_tlrs) &&
      $past(is_train && !i_tlrs, 2) |-> o_d6actestsig_b != $past(o_d6actestsig_b))
      else record_failure("d6actestsig_b did not toggle under TRAIN in RTI");
   assert property (@(posedge ftap_tck) disable iff (!powergood_rst_trst_b)
      is_pulse && i_rti && !i_tlrs && $past(is_pulse && !i_tlrs) |-> !o_d6actestsig_b)
      else record_failure("d6actestsig_b not held low under PULSE in RTI");
   assert property (@(posedge ftap_tck) disable iff (!powergood_rst_trst_b)
      !is_extest |-> o_d6init == ((is_pulse | is_train) & (i_e1dr | i_e2dr)))
      else record_failure("d6init does not follow exit-DR under PULSE or TRAIN");
   // EXTEST init pulse trails capture-DR by one falling edge
   assert property (@(negedge ftap_tck) disable iff (!powergood_rst_trst_b)
      is_extest |-> o_d6init == $past(is_extest && i_capture_dr && !i_tlrs))
      else record_failure("d6init does not follow the delayed capture-DR under EXTEST");

endmodule

bind bscan_top bscan_props u_props (.*);

// File: verif/tb_bscan.sv
// Boundary-scan control block testbench
// TAP strobe sequences per instruction, reset checks and final report

`timescale 1ns/1ps

module tb_bscan;

   import bscan_pkg::*;

   localparam int RESET_CYCLES   = 5;
   // IR load (9), DR scan (11) and RTI dwell (6)
   localparam int INSTR_CYCLES   = 26;
   localparam int SEQ_CYCLES     = RESET_CYCLES + 3 + 8 * INSTR_CYCLES + 2;
   localparam int TIMEOUT_CYCLES = 2 * SEQ_CYCLES;

   logic                ftap_tck;
   logic                powergood_rst_trst_b;
   logic [IR_WIDTH-1:0] i_ireg;
   logic [IR_WIDTH-1:0] i_ir_shift_reg;
   logic                i_update_ir;
   logic                i_tlrs;
   logic                i_rti;
   logic                i_e1dr;
   logic                i_e2dr;
   logic                i_capture_dr;
   logic                i_shift_dr;
   logic                i_update_dr;
   logic                i_shift_ir_neg;
   logic                i_bscan_tdo;
   logic                i_pre_tdo;
   logic                o_bscan_tck;
   logic                o_capturedr;
   logic                o_shiftdr;
   logic                o_updatedr;
   logic                o_updatedr_clk;
   logic                o_chainen;
   logic                o_mode;
   logic                o_highz;
   logic                o_extogen;
   logic                o_extogsig_b;
   logic                o_d6actestsig_b;
   logic                o_d6select;
   logic                o_d6init;
   logic                o_tdo;

   logic [31:0] lfsr = 32'h343d_8bf8;
   int          err_count = 0;
   int          prop_fails = 0;
   int          cycle_count = 0;

   // Opcodes in test order, 0xFF is a non-boundary instruction
   logic [IR_WIDTH-1:0] codes [8] = '{CODE_SAMPLE_PRELOAD, CODE_CLAMP, CODE_HIGHZ,
      CODE_EXTEST, CODE_EXTEST_TOGGLE, CODE_EXTEST_PULSE, CODE_EXTEST_TRAIN, 8'hFF};
   // DR scan through pause so both exit states are visited
   string dr_path [11] = '{"cap", "shift", "shift", "shift", "e1", "pause", "e2",
      "shift", "shift", "e1", "upd"};

   bscan_top DUT (.*);

   always #20 ftap_tck = ~ftap_tck;

   // *************************************************************************
   // Stimulus helpers
   // *************************************************************************
   // Fibonacci LFSR with taps 32 22 2 1
   function automatic logic lfsr_bit();
      logic fb;
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      return fb;
   endfunction

   // One TAP state per clock, driven just after the rising edge
   task automatic tap_cycle(input string st);
      @(posedge ftap_tck);
      #2;
      i_tlrs         = (st == "tlrs");
      i_rti          = (st == "rti");
      i_capture_dr   = (st == "cap");
      i_shift_dr     = (st == "shift");
      i_e1dr         = (st == "e1");
      i_e2dr         = (st == "e2");
      i_update_dr    = (st == "upd");
      i_shift_ir_neg = (st == "sir");
      i_update_ir    = (st == "uir");
      i_bscan_tdo    = lfsr_bit();
      i_pre_tdo      = lfsr_bit();
   endtask

   // Shift and update a new opcode, idle, then scan the DR
   task automatic run_instruction(input logic [IR_WIDTH-1:0] code);
      tap_cycle("sir");
      i_ir_shift_reg = code;
      tap_cycle("sir");
      tap_cycle("uir");
      tap_cycle("rti");
      i_ireg = code;
      repeat (5) tap_cycle("rti");
      foreach (dr_path[i])
         tap_cycle(dr_path[i]);
      repeat (6) tap_cycle("rti");
   endtask

   task automatic check_value(input string name, input logic [9:0] actual,
                              input logic [9:0] expected);
      if (actual !== expected)
      begin
         err_count++;
         $display("error t=%0t %s: got %h, expected %h", $time, name, actual, expected);
      end
   endtask

   // Controls low, active-low waveforms high, TDO from the rest of the TAP
   task automatic check_reset_state();
      check_value("{capturedr..d6init}", {o_capturedr, o_shiftdr, o_updatedr,
                  o_updatedr_clk, o_chainen, o_mode, o_highz, o_extogen, o_d6select,
                  o_d6init}, '0);
      check_value("o_extogsig_b", 10'(o_extogsig_b), 10'd1);
      check_value("o_d6actestsig_b", 10'(o_d6actestsig_b), 10'd1);
      check_value("o_tdo", 10'(o_tdo), 10'(i_pre_tdo));
   endtask

   // Boundary clock follows the TAP clock on both edges
   always @(ftap_tck)
   begin
      #1;
      check_value("o_bscan_tck", 10'(o_bscan_tck), 10'(ftap_tck));
   end

   // *************************************************************************
   // Sequence and report
   // *************************************************************************
   initial
   begin
      ftap_tck             = 1'b0;
      powergood_rst_trst_b = 1'b0;
      i_ireg               = '0;
      i_ir_shift_reg       = '0;
      i_bscan_tdo          = 1'b0;
      i_pre_tdo            = 1'b0;
      {i_update_ir, i_tlrs, i_rti, i_e1dr, i_e2dr, i_capture_dr, i_shift_dr,
       i_update_dr, i_shift_ir_neg} = '0;
      repeat (RESET_CYCLES - 1) @(posedge ftap_tck);
      #10;
      check_reset_state();
      @(posedge ftap_tck);
      #2;
      powergood_rst_trst_b = 1'b1;
      // Again after the first falling edge out of reset
      tap_cycle("rti");
      #8;
      check_reset_state();
      foreach (codes[i])
      begin
         run_instruction(codes[i]);
         if (codes[i] == CODE_EXTEST_TOGGLE)
            repeat (2) tap_cycle("tlrs");
      end
      tap_cycle("rti");
      @(posedge ftap_tck);
      #2;
      prop_fails = DUT.u_props.fail_count;
      $display("checks done: %0d testbench errors, %0d assertion failures",
               err_count, prop_fails);
      if (err_count + prop_fails == 0)
         $display("Simulation finished: PASS");
      else
         $display("Simulation finished: FAIL");
      $finish;
   end

   always @(posedge ftap_tck)
   begin
      cycle_count++;
      if (cycle_count > TIMEOUT_CYCLES)
      begin
         $display("timeout: sequence still running after %0d cycles", TIMEOUT_CYCLES);
         $display("Simulation finished: FAIL");
         $finish;
      end
   end

endmodule
